// ==== logic/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// address and data widths
`define DC_ADDR_W     32
`define DC_WORD_W     32
`define DC_BYTE_OFF_W 2   // byte within a word

// cache geometry
`define DC_OFFSET_W   2   // four words per line
`define DC_INDEX_W    4   // 16 sets
`define DC_WAYS       2

// derived
`define DC_SETS       (1 << `DC_INDEX_W)
`define DC_LINE_W     (`DC_WORD_W * (1 << `DC_OFFSET_W))
`define DC_STRB_W     (`DC_WORD_W / 8)
`define DC_TAG_W      (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W - `DC_BYTE_OFF_W)

`endif

// ==== logic/dcache_geom_pkg.sv ====
`include "dcache_consts.svh"

package dcache_geom_pkg;

    ////////////////////////////////////////////////////////////////////
    // address fields
    ////////////////////////////////////////////////////////////////////

    typedef logic [`DC_TAG_W-1:0]    tag_t;
    typedef logic [`DC_INDEX_W-1:0]  index_t;
    typedef logic [`DC_OFFSET_W-1:0] word_sel_t;   // word within a line

    ////////////////////////////////////////////////////////////////////
    // payload
    ////////////////////////////////////////////////////////////////////

    typedef logic [`DC_WORD_W-1:0]   word_t;
    typedef logic [`DC_LINE_W-1:0]   line_t;       // word 0 in the low bits
    typedef logic [`DC_STRB_W-1:0]   strb_t;       // one bit per byte

    // one bit per way, used for hit, write enable and use pulse
    typedef logic [`DC_WAYS-1:0]     way_mask_t;

endpackage

// ==== logic/dcache_mem_pkg.sv ====
`include "dcache_consts.svh"

package dcache_mem_pkg;

    // memory port address, byte granular
    typedef logic [`DC_ADDR_W-1:0] addr_t;

    // main control states
    typedef enum logic [2:0] {
        IDLE,       // waiting for a request
        LOOKUP,     // tag compare on the buffered request
        MISS_REQ,   // line read issued, waiting for addr_ok
        MISS_WAIT,  // waiting for the line to return
        WRITE_REQ   // write-through issued, waiting for addr_ok
    } ctrl_state_t;

endpackage

// ==== logic/dcache_array_if.sv ====
// link between the control FSM and the tag/data store
interface dcache_array_if;

    // from control
    dcache_geom_pkg::way_mask_t way_we;   // per-way write enable
    logic                       refill;   // whole line from memory, else merged word

    // from store
    dcache_geom_pkg::way_mask_t hit;      // all zero on a miss
    dcache_geom_pkg::word_t     rd_word;  // requested word of the hit way

    modport ctrl (
        output way_we,
        output refill,
        input  hit
    );

    // rd_word is also read back inside the store for the byte merge
    modport store (
        input  way_we,
        input  refill,
        output hit,
        output rd_word
    );

endinterface

// ==== logic/dcache_req_buf.sv ====
`include "dcache_consts.svh"

module dcache_req_buf (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       buf_we,
    input  logic                       req_wr,
    input  dcache_mem_pkg::addr_t      req_addr,
    input  dcache_geom_pkg::word_t     req_wdata,
    input  dcache_geom_pkg::strb_t     req_wstrb,
    output logic                       buf_wr,
    output dcache_geom_pkg::tag_t      buf_tag,
    output dcache_geom_pkg::index_t    buf_index,
    output dcache_geom_pkg::word_sel_t buf_word,
    output dcache_geom_pkg::word_t     buf_wdata,
    output dcache_geom_pkg::strb_t     buf_strb,
    output dcache_mem_pkg::addr_t      buf_addr
);

    dcache_mem_pkg::addr_t addr_q;

    // request kind steers the FSM
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_wr <= 1'b0;
        end else if (buf_we) begin
            buf_wr <= req_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_we) begin
            addr_q    <= req_addr;
            buf_wdata <= req_wdata;
            buf_strb  <= req_wstrb;
        end
    end

    // field split   tag | index | word | byte
    assign buf_tag   = addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign buf_index = addr_q[`DC_BYTE_OFF_W+`DC_OFFSET_W +: `DC_INDEX_W];
    assign buf_word  = addr_q[`DC_BYTE_OFF_W +: `DC_OFFSET_W];
    assign buf_addr  = addr_q;

endmodule

// ==== logic/dcache_lru.sv ====
`include "dcache_consts.svh"

module dcache_lru (
    input  logic                       clk,
    input  logic                       rstn,
    input  dcache_geom_pkg::index_t    buf_index,
    input  dcache_geom_pkg::way_mask_t use_way,
    output logic                       victim
);

    ////////////////////////////////////////////////////////////////////
    // one bit per set naming the least recently used way
    ////////////////////////////////////////////////////////////////////

    logic [`DC_SETS-1:0] lru_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_q <= '0;                           // way 0 goes first
        end else if (|use_way) begin
            lru_q[buf_index] <= use_way[0];        // used way 0 leaves way 1 as oldest
        end
    end

    assign victim = lru_q[buf_index];

endmodule

// ==== logic/dcache_way_store.sv ====
`include "dcache_consts.svh"

module dcache_way_store (
    input  logic                       clk,
    input  logic                       rstn,
    input  dcache_geom_pkg::tag_t      buf_tag,
    input  dcache_geom_pkg::index_t    buf_index,
    input  dcache_geom_pkg::word_sel_t buf_word,
    input  dcache_geom_pkg::word_t     buf_wdata,
    input  dcache_geom_pkg::strb_t     buf_strb,
    input  dcache_geom_pkg::line_t     mem_rdata,
    input  logic                       rsp_from_mem,
    dcache_array_if.store              arr,
    output dcache_geom_pkg::word_t     rsp_rdata
);

    logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;
    dcache_geom_pkg::tag_t             tag_mem  [`DC_WAYS][`DC_SETS];
    dcache_geom_pkg::line_t            data_mem [`DC_WAYS][`DC_SETS];

    dcache_geom_pkg::way_mask_t hit_vec;
    dcache_geom_pkg::line_t     hit_line;
    dcache_geom_pkg::word_t     merged;

    // byte-wise merge of the store data into the old word
    function automatic dcache_geom_pkg::word_t merge_word(
        input dcache_geom_pkg::word_t old_word,
        input dcache_geom_pkg::word_t new_word,
        input dcache_geom_pkg::strb_t strb
    );
        dcache_geom_pkg::word_t res;
        res = old_word;
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_vec[w] = valid_q[w][buf_index] && (tag_mem[w][buf_index] == buf_tag);
            if (hit_vec[w]) begin
                hit_line = data_mem[w][buf_index];
            end
        end
    end

    assign arr.hit     = hit_vec;
    assign arr.rd_word = hit_line[buf_word*`DC_WORD_W +: `DC_WORD_W];
    assign merged      = merge_word(arr.rd_word, buf_wdata, buf_strb);

    // refill word is forwarded straight from the memory beat
    assign rsp_rdata = rsp_from_mem ? mem_rdata[buf_word*`DC_WORD_W +: `DC_WORD_W]
                                    : arr.rd_word;

    ////////////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
        end else begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (arr.way_we[w] && arr.refill) begin
                    valid_q[w][buf_index] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (arr.way_we[w]) begin
                if (arr.refill) begin
                    tag_mem[w][buf_index]  <= buf_tag;
                    data_mem[w][buf_index] <= mem_rdata;
                end else begin             // store hit
                    data_mem[w][buf_index][buf_word*`DC_WORD_W +: `DC_WORD_W] <= merged;
                end
            end
        end
    end

endmodule

// ==== logic/dcache_ctrl.sv ====
module dcache_ctrl (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       req_valid,
    input  logic                       buf_wr,
    input  logic                       mem_addr_ok,
    input  logic                       mem_data_ok,
    dcache_array_if.ctrl               arr,
    output logic                       req_ready,
    output logic                       buf_we,
    output logic                       rsp_valid,
    output logic                       rsp_from_mem,
    output logic                       mem_req,
    output logic                       mem_wr,
    output dcache_geom_pkg::way_mask_t use_way,
    input  logic                       victim
);

    dcache_mem_pkg::ctrl_state_t state, state_nxt;

    logic                       any_hit;
    logic                       load_hit;
    logic                       load_miss;
    dcache_geom_pkg::way_mask_t victim_mask;

    assign any_hit     = |arr.hit;
    assign load_hit    = !buf_wr && any_hit;
    assign load_miss   = !buf_wr && !any_hit;
    assign victim_mask = dcache_geom_pkg::way_mask_t'(1) << victim;

    ////////////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= dcache_mem_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            dcache_mem_pkg::IDLE: begin
                if (req_valid) begin
                    state_nxt = dcache_mem_pkg::LOOKUP;
                end
            end
            dcache_mem_pkg::LOOKUP: begin
                if (buf_wr) begin                  // write-through on hit and miss
                    state_nxt = mem_addr_ok ? dcache_mem_pkg::IDLE
                                            : dcache_mem_pkg::WRITE_REQ;
                end else if (!any_hit) begin
                    state_nxt = mem_addr_ok ? dcache_mem_pkg::MISS_WAIT
                                            : dcache_mem_pkg::MISS_REQ;
                end else if (req_valid) begin
                    state_nxt = dcache_mem_pkg::LOOKUP;   // keep streaming hits
                end else begin
                    state_nxt = dcache_mem_pkg::IDLE;
                end
            end
            dcache_mem_pkg::MISS_REQ: begin
                if (mem_addr_ok) begin
                    state_nxt = dcache_mem_pkg::MISS_WAIT;
                end
            end
            dcache_mem_pkg::MISS_WAIT: begin
                if (mem_data_ok) begin
                    state_nxt = dcache_mem_pkg::IDLE;
                end
            end
            dcache_mem_pkg::WRITE_REQ: begin
                if (mem_addr_ok) begin
                    state_nxt = dcache_mem_pkg::IDLE;
                end
            end
            default: state_nxt = dcache_mem_pkg::IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        req_ready    = 1'b0;
        rsp_valid    = 1'b0;
        rsp_from_mem = 1'b0;
        mem_req      = 1'b0;
        use_way      = '0;
        arr.way_we   = '0;
        arr.refill   = 1'b0;
        case (state)
            dcache_mem_pkg::IDLE: begin
                req_ready = 1'b1;
            end
            dcache_mem_pkg::LOOKUP: begin
                if (load_hit) begin
                    req_ready = 1'b1;
                    rsp_valid = 1'b1;
                    use_way   = arr.hit;
                end else if (load_miss) begin
                    mem_req = 1'b1;                // line read
                end else begin
                    mem_req    = 1'b1;             // word write
                    arr.way_we = arr.hit;          // merge only on a hit
                    use_way    = arr.hit;
                end
            end
            dcache_mem_pkg::MISS_REQ: begin
                mem_req = 1'b1;
            end
            dcache_mem_pkg::MISS_WAIT: begin
                rsp_from_mem = 1'b1;
                arr.refill   = 1'b1;
                if (mem_data_ok) begin
                    rsp_valid  = 1'b1;
                    arr.way_we = victim_mask;
                    use_way    = victim_mask;
                end
            end
            dcache_mem_pkg::WRITE_REQ: begin
                mem_req = 1'b1;
            end
            default: begin
                req_ready = 1'b0;
            end
        endcase
    end

    assign buf_we = req_ready && req_valid;
    assign mem_wr = mem_req && buf_wr;         // kind held in the buffer

endmodule

// ==== logic/dcache_top.sv ====
`include "dcache_consts.svh"

module dcache_top (
    input  logic                   clk,
    input  logic                   rstn,
    // processor side
    input  logic                   req_valid,
    input  logic                   req_wr,
    input  dcache_mem_pkg::addr_t  req_addr,
    input  dcache_geom_pkg::word_t req_wdata,
    input  dcache_geom_pkg::strb_t req_wstrb,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output dcache_geom_pkg::word_t rsp_rdata,
    // memory side
    output logic                   mem_req,
    output logic                   mem_wr,
    output dcache_mem_pkg::addr_t  mem_addr,
    output dcache_geom_pkg::word_t mem_wdata,
    output dcache_geom_pkg::strb_t mem_wstrb,
    input  logic                   mem_addr_ok,
    input  logic                   mem_data_ok,
    input  dcache_geom_pkg::line_t mem_rdata
);

    logic                       buf_we;
    logic                       buf_wr;
    logic                       rsp_from_mem;
    logic                       victim;
    dcache_geom_pkg::way_mask_t use_way;
    dcache_geom_pkg::tag_t      buf_tag;
    dcache_geom_pkg::index_t    buf_index;
    dcache_geom_pkg::word_sel_t buf_word;
    dcache_mem_pkg::addr_t      buf_addr;

    dcache_array_if arr_if ();

    dcache_ctrl i_ctrl (
        .clk(clk), .rstn(rstn),
        .req_valid(req_valid), .buf_wr(buf_wr),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .arr(arr_if),
        .req_ready(req_ready), .buf_we(buf_we),
        .rsp_valid(rsp_valid), .rsp_from_mem(rsp_from_mem),
        .mem_req(mem_req), .mem_wr(mem_wr),
        .use_way(use_way), .victim(victim)
    );

    dcache_req_buf i_req_buf (
        .clk(clk), .rstn(rstn), .buf_we(buf_we),
        .req_wr(req_wr), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_wstrb(req_wstrb),
        .buf_wr(buf_wr), .buf_tag(buf_tag), .buf_index(buf_index),
        .buf_word(buf_word), .buf_wdata(mem_wdata), .buf_strb(mem_wstrb),
        .buf_addr(buf_addr)
    );

    dcache_way_store i_way_store (
        .clk(clk), .rstn(rstn),
        .buf_tag(buf_tag), .buf_index(buf_index), .buf_word(buf_word),
        .buf_wdata(mem_wdata), .buf_strb(mem_wstrb),
        .mem_rdata(mem_rdata), .rsp_from_mem(rsp_from_mem),
        .arr(arr_if), .rsp_rdata(rsp_rdata)
    );

    dcache_lru i_lru (
        .clk(clk), .rstn(rstn),
        .buf_index(buf_index), .use_way(use_way), .victim(victim)
    );

    // word address for writes, line address for refills
    assign mem_addr = mem_wr
        ? {buf_addr[`DC_ADDR_W-1:`DC_BYTE_OFF_W], {`DC_BYTE_OFF_W{1'b0}}}
        : {buf_addr[`DC_ADDR_W-1:`DC_BYTE_OFF_W+`DC_OFFSET_W],
           {(`DC_BYTE_OFF_W+`DC_OFFSET_W){1'b0}}};

endmodule

// ==== testbench/dcache_sva.sv ====
module dcache_sva (
    input logic                   clk,
    input logic                   rstn,
    input logic                   req_valid,
    input logic                   req_wr,
    input logic                   req_ready,
    input logic                   rsp_valid,
    input logic                   mem_req,
    input logic                   mem_wr,
    input dcache_mem_pkg::addr_t  mem_addr,
    input dcache_geom_pkg::word_t mem_wdata,
    input dcache_geom_pkg::strb_t mem_wstrb,
    input logic                   mem_addr_ok,
    input dcache_geom_pkg::way_mask_t use_way,
    input dcache_geom_pkg::way_mask_t hit
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;   // read by the testbench monitor

    //////////////////////////////////////////////////////////////////////
    // memory port
    //////////////////////////////////////////////////////////////////////

    mem_req_holds: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_wr) && $stable(mem_addr)
            && $stable(mem_wdata) && $stable(mem_wstrb))
    else begin
        fail_count++;
        $error("mem_req dropped or its fields changed before mem_addr_ok");
    end

    // idle outputs in reset and right after release
    reset_values: assert property (@(posedge clk)
        (!rstn || $rose(rstn)) |-> req_ready && !mem_req && !rsp_valid && use_way == '0)
    else begin
        fail_count++;
        $error("outputs not at their reset values");
    end

    //////////////////////////////////////////////////////////////////////
    // request timing
    //////////////////////////////////////////////////////////////////////

    // a hit answers next cycle and stays open, a miss goes to memory as a read
    load_answers_next: assert property (@(posedge clk) disable iff (!rstn)
        req_valid && req_ready && !req_wr |=>
            ((|hit) ? (rsp_valid && req_ready && !mem_req)
                    : (mem_req && !mem_wr && !rsp_valid)))
    else begin
        fail_count++;
        $error("accepted load did not answer a hit or read memory on a miss next cycle");
    end

    store_writes_through: assert property (@(posedge clk) disable iff (!rstn)
        req_valid && req_ready && req_wr |=> mem_req && mem_wr && !rsp_valid)
    else begin
        fail_count++;
        $error("accepted store did not issue a memory write");
    end

endmodule

bind dcache_top dcache_sva i_sva (
    .clk(clk), .rstn(rstn),
    .req_valid(req_valid), .req_wr(req_wr), .req_ready(req_ready),
    .rsp_valid(rsp_valid), .mem_req(mem_req), .mem_wr(mem_wr),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
    .mem_addr_ok(mem_addr_ok), .use_way(use_way), .hit(arr_if.hit)
);

// ==== testbench/dcache_tb.sv ====
module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS   = 1024;   // 4 KiB shadow memory
    localparam int WAIT_LIMIT  = 50;
    localparam int EXPECT_MISS = 0;
    localparam int EXPECT_HIT  = 1;
    localparam int EXPECT_ANY  = 2;

    logic                   clk;
    logic                   rstn;
    logic                   req_valid;
    logic                   req_wr;
    dcache_mem_pkg::addr_t  req_addr;
    dcache_geom_pkg::word_t req_wdata;
    dcache_geom_pkg::strb_t req_wstrb;
    logic                   req_ready;
    logic                   rsp_valid;
    dcache_geom_pkg::word_t rsp_rdata;
    logic                   mem_req;
    logic                   mem_wr;
    dcache_mem_pkg::addr_t  mem_addr;
    dcache_geom_pkg::word_t mem_wdata;
    dcache_geom_pkg::strb_t mem_wstrb;
    logic                   mem_addr_ok;
    logic                   mem_data_ok;
    dcache_geom_pkg::line_t mem_rdata;

    dcache_geom_pkg::word_t shadow [MEM_WORDS];
    integer                 seed = 3;
    int                     rd_count = 0;
    int                     wr_count = 0;
    dcache_mem_pkg::addr_t  last_rd_addr;
    dcache_mem_pkg::addr_t  last_wr_addr;
    dcache_geom_pkg::word_t last_wr_data;
    dcache_geom_pkg::strb_t last_wr_strb;

    dcache_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else fail_now($sformatf("Error: %s expected 0x%08h got 0x%08h", name, exp, got));
    endtask

    function automatic logic [9:0] word_index(input dcache_mem_pkg::addr_t a);
        return a[11:2];
    endfunction

    // byte lanes picked by the strobes come from the new data
    function automatic dcache_geom_pkg::word_t apply_strobes(
        input dcache_geom_pkg::word_t old_word,
        input dcache_geom_pkg::word_t new_word,
        input dcache_geom_pkg::strb_t strb
    );
        dcache_geom_pkg::word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!req_ready) begin
            n++;
            if (n > WAIT_LIMIT) fail_now("timeout waiting for req_ready");
            @(negedge clk);
        end
    endtask

    // called at the drive point, returns at the drive point after acceptance
    task automatic send_request(input logic wr, input dcache_mem_pkg::addr_t addr,
                                input dcache_geom_pkg::word_t wdata,
                                input dcache_geom_pkg::strb_t strb);
        req_valid = 1'b1;
        req_wr    = wr;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = strb;
        wait_ready();
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic wait_response(output dcache_geom_pkg::word_t data, output int lat);
        lat = 1;
        @(negedge clk);
        while (!rsp_valid) begin
            lat++;
            if (lat > WAIT_LIMIT) fail_now("timeout waiting for rsp_valid");
            @(negedge clk);
        end
        data = rsp_rdata;
        if (lat > 1) begin
            assert (mem_data_ok) else fail_now("refill response came without data_ok");
        end
        @(posedge clk);
        #2;
    endtask

    task automatic check_load(input dcache_mem_pkg::addr_t addr, input int kind);
        dcache_geom_pkg::word_t exp;
        dcache_geom_pkg::word_t got;
        int                     reads;
        int                     lat;
        exp   = shadow[word_index(addr)];
        reads = rd_count;
        send_request(1'b0, addr, '0, '0);
        wait_response(got, lat);
        check_value("rsp_rdata", got, exp);
        if (kind == EXPECT_HIT) begin
            check_value("rsp_valid latency", lat, 32'd1);
            check_value("memory reads", rd_count, reads);
        end else if (kind == EXPECT_MISS) begin
            check_value("memory reads", rd_count, reads + 1);
            check_value("mem_addr", last_rd_addr, {addr[31:4], 4'h0});
        end
    endtask

    task automatic check_store(input dcache_mem_pkg::addr_t addr,
                               input dcache_geom_pkg::word_t wdata,
                               input dcache_geom_pkg::strb_t strb);
        int writes;
        int n;
        writes = wr_count;
        n      = 0;
        send_request(1'b1, addr, wdata, strb);
        @(negedge clk);
        while (wr_count == writes) begin
            n++;
            if (n > WAIT_LIMIT) fail_now("timeout waiting for the memory write");
            @(negedge clk);
        end
        check_value("mem_addr", last_wr_addr, {addr[31:2], 2'b00});
        check_value("mem_wdata", last_wr_data, wdata);
        check_value("mem_wstrb", 32'(last_wr_strb), 32'(strb));
        @(posedge clk);
        #2;
    endtask

    // two loads back to back, the second accepted in the first's LOOKUP
    task automatic stream_hits(input dcache_mem_pkg::addr_t first,
                               input dcache_mem_pkg::addr_t second);
        int reads;
        reads     = rd_count;
        req_valid = 1'b1;
        req_wr    = 1'b0;
        req_addr  = first;
        wait_ready();
        @(posedge clk);
        #2;
        req_addr = second;
        @(negedge clk);
        assert (rsp_valid && req_ready) else fail_now("back-to-back hit was not accepted");
        check_value("rsp_rdata", rsp_rdata, shadow[word_index(first)]);
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        @(negedge clk);
        assert (rsp_valid) else fail_now("second hit gave no response in the next cycle");
        check_value("rsp_rdata", rsp_rdata, shadow[word_index(second)]);
        check_value("memory reads", rd_count, reads);
        @(posedge clk);
        #2;
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory model, decisions made at the drive point
    //////////////////////////////////////////////////////////////////////

    initial begin : memory_model
        int                    addr_wait;
        int                    data_wait;
        logic                  rd_busy;
        dcache_mem_pkg::addr_t rd_line;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        rd_busy     = 1'b0;
        addr_wait   = 0;
        data_wait   = 0;
        rd_line     = '0;
        forever begin
            @(posedge clk);
            #2;
            mem_addr_ok = 1'b0;
            mem_data_ok = 1'b0;
            if (!rstn) begin
                rd_busy = 1'b0;
            end else if (rd_busy) begin
                if (data_wait == 0) begin
                    for (int w = 0; w < 4; w++) begin
                        mem_rdata[32*w +: 32] = shadow[{rd_line[11:4], 2'(w)}];
                    end
                    mem_data_ok = 1'b1;
                    rd_busy     = 1'b0;
                end else begin
                    data_wait--;
                end
            end else if (mem_req) begin
                if (addr_wait == 0) begin
                    mem_addr_ok = 1'b1;          // taken at the next edge
                    addr_wait   = $random(seed) & 3;
                    if (mem_wr) begin
                        shadow[word_index(mem_addr)] =
                            apply_strobes(shadow[word_index(mem_addr)], mem_wdata, mem_wstrb);
                        last_wr_addr = mem_addr;
                        last_wr_data = mem_wdata;
                        last_wr_strb = mem_wstrb;
                        wr_count++;
                    end else begin
                        rd_busy      = 1'b1;
                        rd_line      = mem_addr;
                        data_wait    = $random(seed) & 3;
                        last_rd_addr = mem_addr;
                        rd_count++;
                    end
                end else begin
                    addr_wait--;
                end
            end
        end
    end

    // bound assertions count their failures
    always @(negedge clk) begin
        if (i_dut.i_sva.fail_count != 0) fail_now("a bound protocol assertion failed");
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        dcache_mem_pkg::addr_t a;
        req_valid = 1'b0;
        req_wr    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        rstn      = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[10'(i)] = {~i[15:0], i[15:0]};
        end
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(negedge clk);
        assert (req_ready && !mem_req && !rsp_valid)
        else fail_now("outputs not idle after reset");
        @(posedge clk);
        #2;

        check_load(32'h104, EXPECT_MISS);            // cold miss
        check_load(32'h108, EXPECT_HIT);
        stream_hits(32'h10c, 32'h100);
        check_store(32'h108, 32'hdeadbeef, 4'b0110); // write-through hit
        check_load(32'h108, EXPECT_HIT);
        check_store(32'h204, 32'h12345678, 4'b1111); // no allocate
        check_load(32'h204, EXPECT_MISS);

        // set 4 with tags A, B, C
        check_load(32'h040, EXPECT_MISS);
        check_load(32'h140, EXPECT_MISS);
        check_load(32'h040, EXPECT_HIT);
        check_load(32'h240, EXPECT_MISS);            // evicts B
        check_load(32'h040, EXPECT_HIT);
        check_load(32'h140, EXPECT_MISS);

        for (int i = 0; i < 40; i++) begin
            a = dcache_mem_pkg::addr_t'($random(seed)) & 32'h3fc;
            if ($random(seed) & 1) begin
                check_store(a, dcache_geom_pkg::word_t'($random(seed)),
                            dcache_geom_pkg::strb_t'($random(seed)));
            end else begin
                check_load(a, EXPECT_ANY);
            end
        end

        repeat (3) @(posedge clk);
        if (i_dut.i_sva.fail_count != 0) begin
            fail_now("a bound protocol assertion failed");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== dcache.f ====
+incdir+logic
logic/dcache_geom_pkg.sv
logic/dcache_mem_pkg.sv
logic/dcache_array_if.sv
logic/dcache_req_buf.sv
logic/dcache_lru.sv
logic/dcache_way_store.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
testbench/dcache_sva.sv
testbench/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the dcache testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module dcache_tb -o dcache_sim -f dcache.f &&
./obj_dir/dcache_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
